/* rtl/mapper_macros.svh */
`ifndef MAPPER_MACROS_SVH
`define MAPPER_MACROS_SVH

// External memory address width, 16 MB flat space
`define MEM_ADDR_W 24

// Battery SRAM sits in the top megabyte
`define SRAM_BASE 24'hF00000

// Bank value that opens the sound chip window
`define SCC_SELECT 8'h3F

`endif

/* rtl/mapper_pkg.sv */
`default_nettype none

`include "mapper_macros.svh"

package mapper_pkg;

    typedef enum logic [2:0] {
        map_none,
        map_offset,
        map_ascii8,
        map_ascii16,
        map_konami_scc
    } mapper_type_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        wr;
        logic        mreq;      // One cycle per access
    } cpu_bus_t;

    typedef struct packed {
        mapper_type_t            mapper;
        logic [`MEM_ADDR_W-1:0] rom_base;
        logic [`MEM_ADDR_W-1:0] rom_mask;    // ROM size minus one
    } block_info_t;

    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        logic                    rnw;
        logic                    ram_cs;    // ROM select
        logic                    sram_cs;
    } mapper_out_t;

    typedef struct packed {
        logic       en;
        logic       we;
        logic [7:0] param;      // Register offset in SCC window
        logic [5:0] data;
    } device_bus_t;

    // Idle value, merges away under AND/OR
    localparam mapper_out_t out_idle = '{addr: '1, rnw: 1'b1, ram_cs: 1'b0, sram_cs: 1'b0};

    function automatic logic [`MEM_ADDR_W-1:0] rom_addr(
        input block_info_t            info,
        input logic [`MEM_ADDR_W-1:0] offset
    );
        return info.rom_base + (offset & info.rom_mask);
    endfunction

endpackage

`default_nettype wire

/* rtl/mapper_offset.sv */
`default_nettype none

`include "mapper_macros.svh"

module mapper_offset (
    input  wire                           clk,          // No state here
    input  wire                           reset,
    input  wire mapper_pkg::cpu_bus_t     cpu,
    input  wire mapper_pkg::block_info_t  block_info,
    output mapper_pkg::mapper_out_t       out
);

    localparam int AW = `MEM_ADDR_W;

    logic        sel_type;
    logic        in_rom;
    logic        active;
    logic [15:0] rel;

    assign sel_type = block_info.mapper == mapper_pkg::map_offset;
    assign in_rom   = cpu.addr[15] ^ cpu.addr[14];     // 0x4000 to 0xBFFF
    assign active   = sel_type && cpu.mreq && in_rom;
    assign rel      = cpu.addr - 16'h4000;

    always_comb begin
        out = mapper_pkg::out_idle;
        if (active && !cpu.wr) begin                    // Writes fall through idle
            out.addr   = mapper_pkg::rom_addr(block_info, {{(AW-15){1'b0}}, rel[14:0]});
            out.ram_cs = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/mapper_ascii8.sv */
`default_nettype none

`include "mapper_macros.svh"

module mapper_ascii8 (
    input  wire                           clk,
    input  wire                           reset,
    input  wire mapper_pkg::cpu_bus_t     cpu,
    input  wire mapper_pkg::block_info_t  block_info,
    output mapper_pkg::mapper_out_t       out
);

    localparam int AW = `MEM_ADDR_W;

    logic [3:0][7:0] bank;
    logic            sel_type;
    logic            in_rom;
    logic            bank_wr;
    logic [1:0]      idx;
    logic [7:0]      bank_val;
    logic            sram_hit;

    assign sel_type = block_info.mapper == mapper_pkg::map_ascii8;
    assign in_rom   = cpu.addr[15] ^ cpu.addr[14];
    assign bank_wr  = sel_type && cpu.mreq && cpu.wr && cpu.addr[15:13] == 3'b011;

    // Page 0x4000 is bank 0, so bits 14:13 are offset by two
    assign idx      = {~cpu.addr[14], cpu.addr[13]};
    assign bank_val = bank[idx];
    assign sram_hit = bank_val[7] && idx[1];           // Only 0x8000 to 0xBFFF

    always_ff @(posedge clk) begin
        if (reset) begin
            bank <= '0;
        end else if (bank_wr) begin
            bank[cpu.addr[12:11]] <= cpu.data;
        end
    end

    always_comb begin
        out = mapper_pkg::out_idle;
        if (sel_type && cpu.mreq && in_rom) begin
            if (sram_hit) begin
                out.addr    = `SRAM_BASE + {{(AW-13){1'b0}}, cpu.addr[12:0]};
                out.rnw     = ~cpu.wr;
                out.sram_cs = 1'b1;
            end else if (!cpu.wr) begin
                out.addr   = mapper_pkg::rom_addr(block_info,
                                                  {{(AW-21){1'b0}}, bank_val, cpu.addr[12:0]});
                out.ram_cs = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/mapper_ascii16.sv */
`default_nettype none

`include "mapper_macros.svh"

module mapper_ascii16 (
    input  wire                           clk,
    input  wire                           reset,
    input  wire mapper_pkg::cpu_bus_t     cpu,
    input  wire mapper_pkg::block_info_t  block_info,
    output mapper_pkg::mapper_out_t       out
);

    localparam int AW = `MEM_ADDR_W;

    logic [1:0][7:0] bank;
    logic            sel_type;
    logic            in_rom;
    logic            bank_wr;
    logic [7:0]      bank_val;
    logic            sram_hit;

    assign sel_type = block_info.mapper == mapper_pkg::map_ascii16;
    assign in_rom   = cpu.addr[15] ^ cpu.addr[14];

    // 0x6000 to 0x67FF and 0x7000 to 0x77FF, bit 12 picks the bank
    assign bank_wr  = sel_type && cpu.mreq && cpu.wr
                      && cpu.addr[15:13] == 3'b011 && !cpu.addr[11];
    assign bank_val = bank[cpu.addr[15]];
    assign sram_hit = cpu.addr[15] && bank[1][7];       // 2K SRAM mirrored

    always_ff @(posedge clk) begin
        if (reset) begin
            bank <= '0;
        end else if (bank_wr) begin
            bank[cpu.addr[12]] <= cpu.data;
        end
    end

    always_comb begin
        out = mapper_pkg::out_idle;
        if (sel_type && cpu.mreq && in_rom) begin
            if (sram_hit) begin
                out.addr    = `SRAM_BASE + {{(AW-11){1'b0}}, cpu.addr[10:0]};
                out.rnw     = ~cpu.wr;
                out.sram_cs = 1'b1;
            end else if (!cpu.wr) begin
                out.addr   = mapper_pkg::rom_addr(block_info,
                                                  {{(AW-22){1'b0}}, bank_val, cpu.addr[13:0]});
                out.ram_cs = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/mapper_konami_scc.sv */
`default_nettype none

`include "mapper_macros.svh"

module mapper_konami_scc (
    input  wire                           clk,
    input  wire                           reset,
    input  wire mapper_pkg::cpu_bus_t     cpu,
    input  wire mapper_pkg::block_info_t  block_info,
    output mapper_pkg::mapper_out_t       out,
    output mapper_pkg::device_bus_t       device
);

    localparam int AW = `MEM_ADDR_W;

    logic [3:0][7:0] bank;
    logic            sel_type;
    logic            access;
    logic            in_rom;
    logic [1:0]      idx;
    logic [7:0]      bank_val;
    logic            bank_wr;
    logic            scc_hit;

    assign sel_type = block_info.mapper == mapper_pkg::map_konami_scc;
    assign access   = sel_type && cpu.mreq;
    assign in_rom   = cpu.addr[15] ^ cpu.addr[14];

    // 8K pages from 0x4000, bank 0 first
    assign idx      = {~cpu.addr[14], cpu.addr[13]};
    assign bank_val = bank[idx];

    // 0x5000, 0x7000, 0x9000, 0xB000, each 2K long
    assign bank_wr  = access && cpu.wr && in_rom && cpu.addr[12:11] == 2'b10;

    assign scc_hit  = access && bank[2] == `SCC_SELECT && cpu.addr[15:11] == 5'b10011;

    always_ff @(posedge clk) begin
        if (reset) begin
            bank <= {8'd3, 8'd2, 8'd1, 8'd0};
        end else if (bank_wr) begin
            bank[idx] <= cpu.data;
        end
    end

    always_comb begin
        device = '0;
        if (scc_hit) begin
            device.en    = 1'b1;
            device.we    = cpu.wr;
            device.param = cpu.addr[7:0];
            device.data  = cpu.data[5:0];
        end
    end

    always_comb begin
        out = mapper_pkg::out_idle;
        if (access && in_rom && !scc_hit && !cpu.wr) begin    // SCC window keeps memory idle
            out.addr   = mapper_pkg::rom_addr(block_info,
                                              {{(AW-21){1'b0}}, bank_val, cpu.addr[12:0]});
            out.ram_cs = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/mappers.sv */
`default_nettype none

module mappers (
    input  wire                           clk,
    input  wire                           reset,
    input  wire mapper_pkg::cpu_bus_t     cpu,
    input  wire mapper_pkg::block_info_t  block_info,
    output mapper_pkg::mapper_out_t       memory,
    output mapper_pkg::device_bus_t       device
);

    mapper_pkg::mapper_out_t offset_out;
    mapper_pkg::mapper_out_t ascii8_out;
    mapper_pkg::mapper_out_t ascii16_out;
    mapper_pkg::mapper_out_t konami_scc_out;

    mapper_offset u_offset (
        .clk        (clk),
        .reset      (reset),
        .cpu        (cpu),
        .block_info (block_info),
        .out        (offset_out)
    );

    mapper_ascii8 u_ascii8 (
        .clk        (clk),
        .reset      (reset),
        .cpu        (cpu),
        .block_info (block_info),
        .out        (ascii8_out)
    );

    mapper_ascii16 u_ascii16 (
        .clk        (clk),
        .reset      (reset),
        .cpu        (cpu),
        .block_info (block_info),
        .out        (ascii16_out)
    );

    mapper_konami_scc u_konami_scc (
        .clk        (clk),
        .reset      (reset),
        .cpu        (cpu),
        .block_info (block_info),
        .out        (konami_scc_out),
        .device     (device)           // Only sound device source
    );

    // Idle mappers drive ones on addr and rnw
    assign memory.addr    = offset_out.addr
                          & ascii8_out.addr
                          & ascii16_out.addr
                          & konami_scc_out.addr;

    assign memory.rnw     = offset_out.rnw
                          & ascii8_out.rnw
                          & ascii16_out.rnw
                          & konami_scc_out.rnw;

    assign memory.ram_cs  = offset_out.ram_cs
                          | ascii8_out.ram_cs
                          | ascii16_out.ram_cs
                          | konami_scc_out.ram_cs;

    assign memory.sram_cs = offset_out.sram_cs
                          | ascii8_out.sram_cs
                          | ascii16_out.sram_cs
                          | konami_scc_out.sram_cs;

endmodule

`default_nettype wire

/* dv/mappers_assertions.sv */
`default_nettype none

module mappers_assertions (
    input wire                          clk,
    input wire                          reset,
    input wire mapper_pkg::mapper_out_t memory,
    input wire mapper_pkg::device_bus_t device
);

    // ROM and SRAM share one bus
    property one_memory_select;
        @(posedge clk) disable iff (reset)
            !(memory.ram_cs && memory.sram_cs);
    endproperty

    // SCC window keeps memory idle
    property device_excludes_memory;
        @(posedge clk) disable iff (reset)
            !(device.en && (memory.ram_cs || memory.sram_cs));
    endproperty

    a_one_memory_select : assert property (one_memory_select)
        else $error("ram_cs and sram_cs high in the same cycle");

    a_device_excludes_memory : assert property (device_excludes_memory)
        else $error("device strobe together with a memory select");

endmodule

bind mappers mappers_assertions u_mappers_assertions (
    .clk    (clk),
    .reset  (reset),
    .memory (memory),
    .device (device)
);

`default_nettype wire

/* dv/tb_mappers.sv */
`default_nettype none

`include "mapper_macros.svh"

module tb_mappers;

    localparam int NUM_ACC    = 400;
    localparam int MAX_CYCLES = 4 * NUM_ACC + 400;     // Four phases, reset, slack

    logic                    clk;
    logic                    reset;
    mapper_pkg::cpu_bus_t    cpu;
    mapper_pkg::block_info_t block_info;
    mapper_pkg::mapper_out_t memory;
    mapper_pkg::device_bus_t device;

    logic [31:0] rng;
    int          errors;
    int          checks;
    int          cycles = 0;
    logic [7:0]  a8_bank  [0:3];                        // Model bank registers
    logic [7:0]  a16_bank [0:1];
    logic [7:0]  scc_bank [0:3];

    mappers u_mappers (
        .clk        (clk),
        .reset      (reset),
        .cpu        (cpu),
        .block_info (block_info),
        .memory     (memory),
        .device     (device)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [15:0] pick_addr(input logic [31:0] r);
        logic [15:0] a;
        if (r[31:30] == 2'd0) begin
            a = r[15:0];                                // Anywhere in 64K
        end else begin
            case (r[29:27])
                3'd0:    a = {5'b01010, r[10:0]};       // 0x5000
                3'd1:    a = {5'b01100, r[10:0]};       // 0x6000
                3'd2:    a = {5'b01110, r[10:0]};       // 0x7000
                3'd3:    a = {5'b10010, r[10:0]};       // 0x9000
                3'd4:    a = {5'b10110, r[10:0]};       // 0xB000
                3'd5:    a = {5'b01101, r[10:0]};       // 0x6800
                default: a = {5'b10011, r[10:0]};       // SCC window
            endcase
        end
        return a;
    endfunction

    function automatic logic [23:0] rom_map(input mapper_pkg::block_info_t b,
                                            input logic [23:0] bank,
                                            input logic [23:0] size,
                                            input logic [23:0] offset);
        logic [23:0] lin;
        lin = bank * size + offset;
        return b.rom_base + (lin & b.rom_mask);
    endfunction

    function automatic logic scc_open(input mapper_pkg::cpu_bus_t c,
                                      input mapper_pkg::block_info_t b);
        return b.mapper == mapper_pkg::map_konami_scc && c.mreq
               && scc_bank[2] == `SCC_SELECT && c.addr >= 16'h9800 && c.addr <= 16'h9FFF;
    endfunction

    function automatic mapper_pkg::mapper_out_t expect_memory(input mapper_pkg::cpu_bus_t c,
                                                              input mapper_pkg::block_info_t b);
        mapper_pkg::mapper_out_t m;
        logic [15:0]             rel;
        logic [1:0]              page;
        logic [7:0]              bv;
        m.addr    = '1;
        m.rnw     = 1'b1;
        m.ram_cs  = 1'b0;
        m.sram_cs = 1'b0;
        rel  = c.addr - 16'h4000;
        page = rel[14:13];                              // 8K page within the window
        if (c.mreq && c.addr >= 16'h4000 && c.addr <= 16'hBFFF) begin
            case (b.mapper)
                mapper_pkg::map_offset: begin
                    if (!c.wr) begin
                        m.addr   = rom_map(b, 24'd0, 24'd32768, {9'd0, rel[14:0]});
                        m.ram_cs = 1'b1;
                    end
                end
                mapper_pkg::map_ascii8: begin
                    bv = a8_bank[page];
                    if (bv[7] && page >= 2'd2) begin
                        m.addr    = `SRAM_BASE + {11'd0, rel[12:0]};
                        m.rnw     = !c.wr;
                        m.sram_cs = 1'b1;
                    end else if (!c.wr) begin
                        m.addr   = rom_map(b, {16'd0, bv}, 24'd8192, {11'd0, rel[12:0]});
                        m.ram_cs = 1'b1;
                    end
                end
                mapper_pkg::map_ascii16: begin
                    bv = a16_bank[c.addr >= 16'h8000];
                    if (c.addr >= 16'h8000 && bv[7]) begin
                        m.addr    = `SRAM_BASE + {13'd0, c.addr[10:0]};
                        m.rnw     = !c.wr;
                        m.sram_cs = 1'b1;
                    end else if (!c.wr) begin
                        m.addr   = rom_map(b, {16'd0, bv}, 24'd16384, {10'd0, c.addr[13:0]});
                        m.ram_cs = 1'b1;
                    end
                end
                mapper_pkg::map_konami_scc: begin
                    if (!c.wr && !scc_open(c, b)) begin
                        m.addr   = rom_map(b, {16'd0, scc_bank[page]}, 24'd8192,
                                           {11'd0, rel[12:0]});
                        m.ram_cs = 1'b1;
                    end
                end
                default: ;
            endcase
        end
        return m;
    endfunction

    function automatic mapper_pkg::device_bus_t expect_device(input mapper_pkg::cpu_bus_t c,
                                                              input mapper_pkg::block_info_t b);
        mapper_pkg::device_bus_t d;
        d = '0;
        if (scc_open(c, b)) begin
            d.en    = 1'b1;
            d.we    = c.wr;
            d.param = c.addr[7:0];
            d.data  = c.data[5:0];
        end
        return d;
    endfunction

    task automatic check_outputs();
        mapper_pkg::mapper_out_t exp_mem;
        mapper_pkg::device_bus_t exp_dev;
        exp_mem = expect_memory(cpu, block_info);
        exp_dev = expect_device(cpu, block_info);
        checks = checks + 2;
        assert (memory === exp_mem) else begin
            errors++;
            $display("FAILED @%0t: memory %h, expected %h (mapper %0d addr %h wr %b)",
                     $time, memory, exp_mem, block_info.mapper, cpu.addr, cpu.wr);
        end
        assert (device === exp_dev) else begin
            errors++;
            $display("FAILED @%0t: device %h, expected %h (mapper %0d addr %h wr %b)",
                     $time, device, exp_dev, block_info.mapper, cpu.addr, cpu.wr);
        end
    endtask

    // Bank writes land at the next edge, after this cycle's check
    task automatic update_model();
        if (cpu.mreq && cpu.wr) begin
            case (block_info.mapper)
                mapper_pkg::map_ascii8: begin
                    if (cpu.addr >= 16'h6000 && cpu.addr <= 16'h7FFF)
                        a8_bank[cpu.addr[12:11]] = cpu.data;
                end
                mapper_pkg::map_ascii16: begin
                    if (cpu.addr >= 16'h6000 && cpu.addr <= 16'h67FF)
                        a16_bank[0] = cpu.data;
                    else if (cpu.addr >= 16'h7000 && cpu.addr <= 16'h77FF)
                        a16_bank[1] = cpu.data;
                end
                mapper_pkg::map_konami_scc: begin
                    case (cpu.addr[15:11])
                        5'h0A:   scc_bank[0] = cpu.data;
                        5'h0E:   scc_bank[1] = cpu.data;
                        5'h12:   scc_bank[2] = cpu.data;
                        5'h16:   scc_bank[3] = cpu.data;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    endtask

    task automatic run_phase(input mapper_pkg::mapper_type_t kind);
        mapper_pkg::block_info_t info;
        logic [31:0]             r;
        int                      shift;
        rng = xorshift(rng);
        shift = 15 + int'(rng[10:8]);                   // ROM of 32K to 4M
        info.mapper   = kind;
        info.rom_base = {rng[7:0], 16'h0000};
        info.rom_mask = (24'd1 << shift) - 24'd1;
        for (int i = 0; i < NUM_ACC; i++) begin
            rng = xorshift(rng);
            r = rng;
            block_info = info;
            if (r[31:28] == 4'd0)                       // Now and then another mapper
                block_info.mapper = mapper_pkg::mapper_type_t'(r[27:25] % 3'd5);
            cpu.mreq = r[24:22] != 3'd0;
            cpu.wr   = r[21];
            cpu.data = (r[1:0] == 2'd0) ? `SCC_SELECT : r[9:2];
            rng = xorshift(rng);
            cpu.addr = pick_addr(rng);
            #8;
            check_outputs();
            update_model();
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        errors     = 0;
        checks     = 0;
        rng        = 32'd45;
        reset      = 1'b1;
        cpu        = '0;
        block_info = '0;
        a8_bank    = '{8'd0, 8'd0, 8'd0, 8'd0};
        a16_bank   = '{8'd0, 8'd0};
        scc_bank   = '{8'd0, 8'd1, 8'd2, 8'd3};
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int k = 0; k < 5; k++) begin               // No strobe, every type
            block_info.mapper = mapper_pkg::mapper_type_t'(k[2:0]);
            #8;
            checks++;
            assert (!memory.ram_cs && !memory.sram_cs && !device.en) else begin
                errors++;
                $display("FAILED @%0t: select active with no strobe, mapper %0d", $time, k);
            end
            @(posedge clk);
            #2;
        end
        run_phase(mapper_pkg::map_offset);
        run_phase(mapper_pkg::map_ascii8);
        run_phase(mapper_pkg::map_ascii16);
        run_phase(mapper_pkg::map_konami_scc);
        cpu = '0;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+rtl
rtl/mapper_pkg.sv
rtl/mapper_offset.sv
rtl/mapper_ascii8.sv
rtl/mapper_ascii16.sv
rtl/mapper_konami_scc.sv
rtl/mappers.sv
dv/mappers_assertions.sv
dv/tb_mappers.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and look for the success line in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_mappers -o sim_mappers \
    && ./obj_dir/sim_mappers 2>&1 | tee /dev/stderr | grep -qxF '*** PASSED ***' \
    && echo "Simulation run succeeded" \
    || { echo "Simulation run did not succeed"; exit 1; }

exit 0
